// File: source/cache_pkg.sv
// shared widths for the cache and memory buses
// cache line union with word and beat views
package cache_pkg;

  // processor side
  localparam int word_w = 16;          // one processor word
  localparam int addr_w = 16;          // word address, not byte

  // memory side
  localparam int beat_w = 32;          // one memory bus transfer

  // line geometry
  localparam int words_per_line = 4;
  localparam int offset_w       = 2;   // picks word within line
  localparam int beats_per_line = 2;   // two words per beat

  // one 64-bit line, seen two ways
  // words[0] is the lowest word
  // beats[0] holds words 0 and 1, word 0 in the low half
  typedef union packed {
    logic [words_per_line-1:0][word_w-1:0] words;  // processor view
    logic [beats_per_line-1:0][beat_w-1:0] beats;  // memory view
  } cache_line_t;

endpackage

// File: source/cache_array_if.sv
// controller to tag/data array connection
// ctrl, tag and data modports
interface cache_array_if import cache_pkg::*; #(
  parameter int index_w = 3
) ();

  localparam int tag_w = addr_w - index_w - offset_w;

  logic [index_w-1:0] index;      // line select, shared by both arrays

  // tag array write side
  logic               tag_we;
  logic [tag_w-1:0]   tag_in;
  logic               valid_in;
  logic               dirty_in;

  // tag array read side, combinational at index
  logic [tag_w-1:0]   tag_out;
  logic               valid_out;
  logic               dirty_out;

  // data array
  logic               data_we;    // whole line write
  cache_line_t        line_in;
  cache_line_t        line_out;

  modport ctrl (
    output index, tag_we, tag_in, valid_in, dirty_in, data_we, line_in,
    input  tag_out, valid_out, dirty_out, line_out
  );

  modport tag  (input index, tag_we, tag_in, valid_in, dirty_in,
                output tag_out, valid_out, dirty_out);

  modport data (input index, data_we, line_in, output line_out);

endinterface

// File: source/cache_tag_ram.sv
// tag, valid and dirty store, one entry per line
module cache_tag_ram import cache_pkg::*; #(
  parameter int index_w = 3
) (
  input  logic        clk,
  input  logic        rst,
  cache_array_if.tag  arr
);

  localparam int tag_w = addr_w - index_w - offset_w;
  localparam int lines = 1 << index_w;

  logic [tag_w-1:0] tag_mem [lines];   // tag per line
  logic [lines-1:0] valid_mem;         // status bits kept as flat vectors
  logic [lines-1:0] dirty_mem;         // so reset clears them in one cycle

  // async read at current index
  assign arr.tag_out   = tag_mem[arr.index];
  assign arr.valid_out = valid_mem[arr.index];
  assign arr.dirty_out = dirty_mem[arr.index];

  // tag field, meaningless until valid
  always_ff @(posedge clk) begin
    if (arr.tag_we) begin
      tag_mem[arr.index] <= arr.tag_in;
    end
  end

  // status bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_mem <= '0;               // every line invalid
      dirty_mem <= '0;
    end else if (arr.tag_we) begin
      valid_mem[arr.index] <= arr.valid_in;
      dirty_mem[arr.index] <= arr.dirty_in;
    end
  end

endmodule

// File: source/cache_data_ram.sv
// line data store, one union line per index
module cache_data_ram import cache_pkg::*; #(
  parameter int index_w = 3
) (
  input  logic        clk,
  cache_array_if.data arr
);

  localparam int lines = 1 << index_w;

  cache_line_t line_mem [lines];     // one 64-bit line per index

  // combinational read, controller picks the view
  assign arr.line_out = line_mem[arr.index];

  // whole line write
  // word merge and beat fill are done upstream
  always_ff @(posedge clk) begin
    if (arr.data_we) begin
      line_mem[arr.index] <= arr.line_in;
    end
  end

endmodule

// File: source/cache_controller.sv
// direct-mapped write-back cache FSM
// hit/miss handling, word select and merge, memory beat sequencing
module cache_controller import cache_pkg::*; #(
  parameter int index_w = 3
) (
  input  logic              clk,
  input  logic              rst,
  // processor side
  input  logic              cpu_valid,
  input  logic              cpu_rw,       // 1 = write
  input  logic [addr_w-1:0] cpu_addr,
  input  logic [word_w-1:0] cpu_wdata,
  output logic              cpu_ready,    // one-cycle pulse
  output logic [word_w-1:0] cpu_rdata,
  // memory side
  output logic              mem_valid,
  output logic              mem_rw,       // 1 = write beat
  output logic [addr_w-1:0] mem_addr,
  output logic [beat_w-1:0] mem_wdata,
  input  logic              mem_ready,    // completes current beat
  input  logic [beat_w-1:0] mem_rdata,
  // tag and data arrays
  cache_array_if.ctrl       arr
);

  localparam int tag_w = addr_w - index_w - offset_w;

  // FSM encoding
  localparam logic [2:0] idle         = 3'd0;
  localparam logic [2:0] compare_tag  = 3'd1;
  localparam logic [2:0] write_back_0 = 3'd2;
  localparam logic [2:0] write_back_1 = 3'd3;
  localparam logic [2:0] allocate_0   = 3'd4;
  localparam logic [2:0] allocate_1   = 3'd5;

  logic [2:0]          state;
  logic [2:0]          state_next;

  // request address fields
  logic [tag_w-1:0]    cpu_tag;
  logic [index_w-1:0]  cpu_index;
  logic [offset_w-1:0] cpu_offset;

  logic                hit;
  logic                second_beat;   // beat 1 of write-back or fill
  logic [offset_w-1:0] beat_offset;   // word offset of current beat
  logic [tag_w-1:0]    victim_tag;    // old tag, kept for write-back

  // split address: tag | index | offset
  assign cpu_tag    = cpu_addr[addr_w-1 -: tag_w];
  assign cpu_index  = cpu_addr[offset_w +: index_w];
  assign cpu_offset = cpu_addr[offset_w-1:0];

  // request is held steady, so arrays always look at its line
  assign arr.index = cpu_index;

  assign hit = arr.valid_out && (arr.tag_out == cpu_tag);

  // word view of the line for reads
  // only meaningful while cpu_ready is high
  assign cpu_rdata = arr.line_out.words[cpu_offset];

  // memory request is a pure function of state
  // stays high over all beats of one miss
  assign mem_valid = (state == write_back_0) || (state == write_back_1) ||
                     (state == allocate_0)   || (state == allocate_1);
  assign mem_rw    = (state == write_back_0) || (state == write_back_1);

  assign second_beat = (state == write_back_1) || (state == allocate_1);
  assign beat_offset = {second_beat, 1'b0};        // 0 or 2

  // victim base on write-back, new line base on fill
  assign mem_addr = {(mem_rw ? victim_tag : cpu_tag), cpu_index, beat_offset};

  // write-back data straight from the beat view
  // data array untouched until the fill, so victim still sits there
  assign mem_wdata = arr.line_out.beats[second_beat];

  always_comb begin
    state_next   = state;
    cpu_ready    = 1'b0;
    // tag write defaults, new tag valid and clean
    arr.tag_we   = 1'b0;
    arr.tag_in   = cpu_tag;
    arr.valid_in = 1'b1;
    arr.dirty_in = 1'b0;
    // data write defaults to the stored line
    arr.data_we  = 1'b0;
    arr.line_in  = arr.line_out;

    case (state)
      idle: begin
        if (cpu_valid) begin
          state_next = compare_tag;
        end
      end

      compare_tag: begin
        if (hit) begin
          cpu_ready  = 1'b1;
          state_next = idle;
          if (cpu_rw) begin
            // merge one word into the line
            arr.line_in.words[cpu_offset] = cpu_wdata;
            arr.data_we  = 1'b1;
            arr.tag_we   = 1'b1;
            arr.dirty_in = 1'b1;         // line now differs from memory
          end
        end else begin
          // claim the entry for the new tag
          // old valid/dirty still visible this cycle
          arr.tag_we = 1'b1;
          if (arr.valid_out && arr.dirty_out) begin
            state_next = write_back_0;   // flush victim first
          end else begin
            state_next = allocate_0;     // clean or empty, fill now
          end
        end
      end

      write_back_0: begin
        if (mem_ready) begin
          state_next = write_back_1;
        end
      end

      write_back_1: begin
        if (mem_ready) begin
          state_next = allocate_0;       // victim flushed
        end
      end

      allocate_0: begin
        if (mem_ready) begin
          arr.line_in.beats[0] = mem_rdata;   // words 0 and 1
          arr.data_we          = 1'b1;
          state_next           = allocate_1;
        end
      end

      allocate_1: begin
        if (mem_ready) begin
          // merge with beat 0 already stored
          arr.line_in.beats[1] = mem_rdata;
          arr.data_we          = 1'b1;
          // re-compare, write miss then finishes as write hit
          state_next           = compare_tag;
        end
      end

      default: state_next = idle;
    endcase
  end

  // victim tag captured on the miss cycle, before the tag array is overwritten
  always_ff @(posedge clk) begin
    if ((state == compare_tag) && !hit) begin
      victim_tag <= arr.tag_out;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

endmodule

// File: source/cache_top.sv
// cache top level with plain processor and memory ports
// joins controller, tag array and data array
module cache_top import cache_pkg::*; #(
  parameter int index_w = 3           // 2**index_w lines
) (
  input  logic              clk,
  input  logic              rst,
  // processor port
  input  logic              cpu_valid,
  input  logic              cpu_rw,
  input  logic [addr_w-1:0] cpu_addr,
  input  logic [word_w-1:0] cpu_wdata,
  output logic              cpu_ready,
  output logic [word_w-1:0] cpu_rdata,
  // memory bus
  output logic              mem_valid,
  output logic              mem_rw,
  output logic [addr_w-1:0] mem_addr,
  output logic [beat_w-1:0] mem_wdata,
  input  logic              mem_ready,
  input  logic [beat_w-1:0] mem_rdata
);

  cache_array_if #(.index_w(index_w)) arr ();   // controller to arrays

  cache_controller #(.index_w(index_w)) u_controller (
    .clk       (clk),
    .rst       (rst),
    .cpu_valid (cpu_valid),
    .cpu_rw    (cpu_rw),
    .cpu_addr  (cpu_addr),
    .cpu_wdata (cpu_wdata),
    .cpu_ready (cpu_ready),
    .cpu_rdata (cpu_rdata),
    .mem_valid (mem_valid),
    .mem_rw    (mem_rw),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_ready (mem_ready),
    .mem_rdata (mem_rdata),
    .arr       (arr.ctrl)
  );

  // tag/valid/dirty, valid bits cleared by rst
  cache_tag_ram #(.index_w(index_w)) u_tag_ram (
    .clk (clk),
    .rst (rst),
    .arr (arr.tag)
  );

  cache_data_ram #(.index_w(index_w)) u_data_ram (
    .clk (clk),
    .arr (arr.data)
  );

endmodule

// File: tests/mem_model.sv
// behavioral 32-bit memory with random ready delay
// beat counters and recent addresses for the testbench
module mem_model import cache_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              mem_valid,
  input  logic              mem_rw,
  input  logic [addr_w-1:0] mem_addr,
  input  logic [beat_w-1:0] mem_wdata,
  output logic              mem_ready,
  output logic [beat_w-1:0] mem_rdata
);

  logic [word_w-1:0] store [65536];    // one entry per word address
  logic              busy;             // beat seen, counting down
  logic [1:0]        wait_cnt;
  int                read_beats;
  int                write_beats;
  logic [addr_w-1:0] last_rd_addr;
  logic [addr_w-1:0] prev_rd_addr;
  logic [addr_w-1:0] last_wr_addr;
  logic [addr_w-1:0] prev_wr_addr;

  initial begin
    mem_ready = 1'b0;
    mem_rdata = '0;
    for (int i = 0; i < 65536; i++) begin
      store[i] = 16'(i) ^ 16'ha5c3;    // pattern over the whole address
    end
  end

  always @(posedge clk) begin
    mem_ready <= 1'b0;                 // pulse lasts one cycle
    if (rst) begin
      busy        <= 1'b0;
      read_beats  <= 0;
      write_beats <= 0;
    end else if (mem_ready) begin
      busy <= 1'b0;                    // gap cycle, address moves on
    end else if (mem_valid && !busy) begin
      busy     <= 1'b1;
      wait_cnt <= 2'($urandom % 4);    // ready after 1 to 4 cycles
    end else if (busy && wait_cnt != 2'd0) begin
      wait_cnt <= wait_cnt - 2'd1;
    end else if (busy) begin
      mem_ready <= 1'b1;
      if (mem_rw) begin
        store[mem_addr]         <= mem_wdata[15:0];   // low half, lower word
        store[mem_addr + 16'd1] <= mem_wdata[31:16];
        write_beats  <= write_beats + 1;
        prev_wr_addr <= last_wr_addr;
        last_wr_addr <= mem_addr;
      end else begin
        mem_rdata    <= {store[mem_addr + 16'd1], store[mem_addr]};
        read_beats   <= read_beats + 1;
        prev_rd_addr <= last_rd_addr;
        last_rd_addr <= mem_addr;
      end
    end
  end

endmodule

// File: tests/cache_tb.sv
// testbench with clock, reset, DUT, memory model and shadow memory
// check task, processor access task and directed tests
module cache_tb import cache_pkg::*; ();

  localparam int timeout_cycles = 200;   // per processor access

  logic              clk;
  logic              rst;
  logic              cpu_valid;
  logic              cpu_rw;
  logic [addr_w-1:0] cpu_addr;
  logic [word_w-1:0] cpu_wdata;
  logic              cpu_ready;
  logic [word_w-1:0] cpu_rdata;
  logic              mem_valid;
  logic              mem_rw;
  logic [addr_w-1:0] mem_addr;
  logic [beat_w-1:0] mem_wdata;
  logic              mem_ready;
  logic [beat_w-1:0] mem_rdata;

  logic [word_w-1:0] shadow [65536];     // expected contents, word addressed
  int                errors;
  int                reads_before;       // beat counts at start of a test
  int                writes_before;

  cache_top u_cache_top (.*);
  mem_model u_mem (.*);

  always #2 clk = ~clk;

  task automatic check_equal(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got %h expected %h", name, actual, expected);
      errors++;
    end
  endtask

  // one request, held until cpu_ready is seen
  // edges counts from the edge that samples cpu_valid to the one that samples ready
  task automatic cpu_access(input logic rw, input logic [addr_w-1:0] addr,
                            input logic [word_w-1:0] wdata,
                            output logic [word_w-1:0] rdata, output int edges);
    int n;
    bit done;
    n = 0;
    done = 1'b0;
    rdata = '0;
    cpu_valid = 1'b1;
    cpu_rw    = rw;
    cpu_addr  = addr;
    cpu_wdata = wdata;
    while (!done && n < timeout_cycles) begin
      @(posedge clk);
      #1;
      n++;
      if (cpu_ready) begin
        done  = 1'b1;
        rdata = cpu_rdata;       // valid with the ready pulse
      end
    end
    edges = n + 1;
    if (!done) begin
      $display("timeout: cpu_ready never came for address %h", addr);
      errors++;
    end
    @(posedge clk);            // edge that samples ready
    #1;
    cpu_valid = 1'b0;
    if (rw) begin
      shadow[addr] = wdata;
    end
  endtask

  task automatic read_check(input logic [addr_w-1:0] addr, output int edges);
    logic [word_w-1:0] data;
    cpu_access(1'b0, addr, '0, data, edges);
    check_equal($sformatf("cpu_rdata at %h", addr), 32'(data), 32'(shadow[addr]));
  endtask

  task automatic write_word(input logic [addr_w-1:0] addr, input logic [word_w-1:0] data);
    logic [word_w-1:0] unused_rd;
    int edges;
    cpu_access(1'b1, addr, data, unused_rd, edges);
  endtask

  task automatic mark_beats();
    reads_before  = u_mem.read_beats;
    writes_before = u_mem.write_beats;
  endtask

  task automatic check_beats(input int reads, input int writes);
    check_equal("read beats", 32'(u_mem.read_beats - reads_before), 32'(reads));
    check_equal("write beats", 32'(u_mem.write_beats - writes_before), 32'(writes));
  endtask

  task automatic end_test(input string name, input int errors_before);
    $display("test %s finished, %0d errors", name, errors - errors_before);
  endtask

  task automatic test_cold_read();
    int e0;
    int edges;
    e0 = errors;
    check_equal("cpu_ready", 32'(cpu_ready), 32'd0);   // idle after reset
    check_equal("mem_valid", 32'(mem_valid), 32'd0);
    mark_beats();
    read_check(16'h0125, edges);                         // index 1, word 1
    check_beats(2, 0);
    check_equal("first read addr", 32'(u_mem.prev_rd_addr), 32'h0124);
    check_equal("second read addr", 32'(u_mem.last_rd_addr), 32'h0126);
    end_test("cold read", e0);
  endtask

  task automatic test_read_hit();
    int e0;
    int edges;
    e0 = errors;
    mark_beats();
    for (int k = 0; k < 4; k++) begin
      read_check(16'h0124 + 16'(k), edges);
      check_equal("hit edges", 32'(edges), 32'd2);
    end
    check_beats(0, 0);                                   // all hits
    end_test("read hit", e0);
  endtask

  task automatic test_write_hit();
    int e0;
    int edges;
    e0 = errors;
    mark_beats();
    write_word(16'h0126, 16'hbeef);                      // word 2 of cached line
    for (int k = 0; k < 4; k++) begin
      read_check(16'h0124 + 16'(k), edges);
    end
    check_beats(0, 0);
    end_test("write hit", e0);
  endtask

  task automatic test_write_miss();
    int e0;
    int edges;
    e0 = errors;
    mark_beats();
    write_word(16'h0a4b, 16'h1357);                      // index 2, still invalid
    check_beats(2, 0);
    read_check(16'h0a4b, edges);
    end_test("write miss", e0);
  endtask

  task automatic test_dirty_eviction();
    int e0;
    int edges;
    e0 = errors;
    mark_beats();
    read_check(16'h3124, edges);                         // index 1, new tag
    check_beats(2, 2);
    check_equal("first write addr", 32'(u_mem.prev_wr_addr), 32'h0124);
    check_equal("second write addr", 32'(u_mem.last_wr_addr), 32'h0126);
    check_equal("first read addr", 32'(u_mem.prev_rd_addr), 32'h3124);
    check_equal("second read addr", 32'(u_mem.last_rd_addr), 32'h3126);
    for (int k = 0; k < 4; k++) begin
      check_equal($sformatf("memory word %0d", k), 32'(u_mem.store[16'h0124 + 16'(k)]),
                  32'(shadow[16'h0124 + 16'(k)]));
    end
    read_check(16'h0126, edges);                         // victim word again
    end_test("dirty eviction", e0);
  endtask

  task automatic test_random_mix();
    int e0;
    int edges;
    logic [addr_w-1:0] addr;
    e0 = errors;
    for (int i = 0; i < 300; i++) begin
      // one of 6 tags, any index and offset
      addr = {11'(($urandom % 6) * 113 + 7), 5'($urandom)};
      if ($urandom % 2 == 1) begin
        write_word(addr, 16'($urandom));
      end else begin
        read_check(addr, edges);
      end
    end
    end_test("random mix", e0);
  endtask

  initial begin
    void'($urandom(57536));
    clk       = 1'b0;
    rst       = 1'b1;
    cpu_valid = 1'b0;
    cpu_rw    = 1'b0;
    cpu_addr  = '0;
    cpu_wdata = '0;
    errors    = 0;
    for (int i = 0; i < 65536; i++) begin
      shadow[i] = 16'(i) ^ 16'ha5c3;     // same fill as the memory model
    end
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    test_cold_read();
    test_read_hit();
    test_write_hit();
    test_write_miss();
    test_dirty_eviction();
    test_random_mix();
    $display("all tests done, %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: all.f
source/cache_pkg.sv
source/cache_array_if.sv
source/cache_tag_ram.sv
source/cache_data_ram.sv
source/cache_controller.sv
source/cache_top.sv
tests/mem_model.sv
tests/cache_tb.sv

// File: Makefile
TOP = cache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f all.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" sim.log || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
